//--- design/irq_pkg.sv
package irq_pkg;

	// Number of interrupt levels, level 0 is the most urgent
	localparam int IRQ_LEVELS = 16;

	typedef logic [0:3] level_t;
	typedef logic [0:IRQ_LEVELS-1] irq_vec_t;
	typedef logic [0:15] word_t;

	// Fixed source levels
	localparam level_t LVL_POWER = 4'd0;
	localparam level_t LVL_CLOCK = 4'd5;
	localparam level_t LVL_OPRQ = 4'd7;

	// Bus devices start here, three bits of rdt_ select the offset
	localparam level_t LVL_EXT_BASE = 4'd8;

	// Everything enabled out of reset
	localparam irq_vec_t MASK_RESET = '1;

	// One-hot vector with the bit of a level set
	function automatic irq_vec_t level_bit(input level_t lvl);
		irq_vec_t v;
		v = '0;
		v[lvl] = 1'b1;
		return v;
	endfunction

endpackage

//--- design/irq_lines_if.sv
`timescale 1ns/1ps

interface irq_lines_if;
	import irq_pkg::*;

	// One-cycle set pulse per level
	irq_vec_t set_req;
	// Enabled levels
	irq_vec_t mask;
	// Master clear, same value on every bit
	irq_vec_t clr_all;
	// Clear of the acknowledged level
	irq_vec_t ack_clr;
	// Pending and enabled
	irq_vec_t ready;

	modport intake (
		output set_req,
		output mask,
		output clr_all
	);

	modport encoder (
		input  ready,
		output ack_clr
	);

endinterface

//--- design/irq_intake.sv
`timescale 1ns/1ps

module irq_intake (
	input  logic           __clk,
	input  logic           rst_n,
	input  logic           clm_,
	input  logic           pout_,
	input  logic           zegar_,
	input  logic           oprq_,
	input  logic           rin_,
	input  irq_pkg::word_t rdt_,
	input  irq_pkg::word_t w,
	input  logic           sint,
	input  logic           mask_load,
	output logic           dok_,
	irq_lines_if.intake    lines
);
	import irq_pkg::*;

	// Active-low sources, bit 0 power, 1 clock, 2 operator, 3 bus
	logic [0:3] src;
	logic [0:3] src_q;
	logic [0:3] fall;

	level_t sint_lvl;
	level_t bus_lvl;

	irq_vec_t set_d;
	irq_vec_t set_q;
	irq_vec_t mask_d;
	irq_vec_t mask_q;
	irq_vec_t clr_q;

	// ------------------------------------------------------------------------
	// Edge detection
	// ------------------------------------------------------------------------

	assign src = {pout_, zegar_, oprq_, rin_};

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			src_q <= '1;
		end else begin
			src_q <= src;
		end
	end

	// High then low: one request per falling edge
	assign fall = src_q & ~src;

	// ------------------------------------------------------------------------
	// Level decode
	// ------------------------------------------------------------------------

	// Low four bits of w
	assign sint_lvl = w[12:15];

	// Bus lines are active low, so the offset is inverted
	assign bus_lvl = LVL_EXT_BASE + {1'b0, ~rdt_[13:15]};

	always_comb begin
		set_d = '0;
		if (fall[0])
			set_d |= level_bit(LVL_POWER);
		if (fall[1])
			set_d |= level_bit(LVL_CLOCK);
		if (fall[2])
			set_d |= level_bit(LVL_OPRQ);
		if (sint)
			set_d |= level_bit(sint_lvl);
		if (fall[3])
			set_d |= level_bit(bus_lvl);
	end

	// Level 0 can not be masked off
	always_comb begin
		mask_d = w;
		mask_d[0] = 1'b1;
	end

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			set_q <= '0;
			clr_q <= '0;
			mask_q <= MASK_RESET;
			dok_ <= 1'b1;
		end else begin
			set_q <= set_d;
			clr_q <= {IRQ_LEVELS{~clm_}};
			// Bus answer in the same cycle as the set pulse
			dok_ <= ~fall[3];
			if (mask_load)
				mask_q <= mask_d;
		end
	end

	assign lines.set_req = set_q;
	assign lines.mask = mask_q;
	assign lines.clr_all = clr_q;

endmodule

//--- design/irq_channel.sv
`timescale 1ns/1ps

module irq_channel (
	input  logic __clk,
	input  logic rst_n,
	input  logic set_req,
	input  logic mask,
	input  logic clr_all,
	input  logic ack_clr,
	output logic ready
);

	logic pending;

	// Clear takes precedence over a new request
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (clr_all || ack_clr) begin
			pending <= 1'b0;
		end else if (set_req) begin
			pending <= 1'b1;
		end
	end

	// Masked requests stay pending and come back on unmask
	assign ready = pending & mask;

endmodule

//--- design/irq_priority.sv
`timescale 1ns/1ps

module irq_priority (
	input  logic            __clk,
	input  logic            rst_n,
	input  logic            inta,
	output logic            irq,
	output irq_pkg::level_t irq_level,
	irq_lines_if.encoder    lines
);
	import irq_pkg::*;

	irq_vec_t ack;
	irq_vec_t avail;
	level_t first;

	// ------------------------------------------------------------------------
	// Acknowledge
	// ------------------------------------------------------------------------

	always_comb begin
		ack = '0;
		if (inta && irq)
			ack = level_bit(irq_level);
	end

	assign lines.ack_clr = ack;

	// Level being cleared this cycle must not show up again
	assign avail = lines.ready & ~ack;

	// ------------------------------------------------------------------------
	// Priority encoder
	// ------------------------------------------------------------------------

	// Scan from the top so the lowest set level is the last one written
	always_comb begin
		first = '0;
		for (int i = IRQ_LEVELS - 1; i >= 0; i--) begin
			if (avail[i])
				first = level_t'(i);
		end
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			irq <= 1'b0;
			irq_level <= '0;
		end else begin
			irq <= |avail;
			// Keep the last level while nothing is ready
			if (|avail)
				irq_level <= first;
		end
	end

endmodule

//--- design/irq_board.sv
`timescale 1ns/1ps

module irq_board (
	input  logic            __clk,
	input  logic            rst_n,
	input  logic            clm_,
	input  logic            pout_,
	input  logic            zegar_,
	input  logic            oprq_,
	input  logic            rin_,
	input  irq_pkg::word_t  rdt_,
	input  irq_pkg::word_t  w,
	input  logic            sint,
	input  logic            mask_load,
	input  logic            inta,
	output logic            dok_,
	output logic            irq,
	output irq_pkg::level_t irq_level
);
	import irq_pkg::*;

	irq_lines_if lines ();

	// ------------------------------------------------------------------------
	// --- Intake -------------------------------------------------------------
	// ------------------------------------------------------------------------

	irq_intake intake (
		.__clk(__clk),
		.rst_n(rst_n),
		.clm_(clm_),
		.pout_(pout_),
		.zegar_(zegar_),
		.oprq_(oprq_),
		.rin_(rin_),
		.rdt_(rdt_),
		.w(w),
		.sint(sint),
		.mask_load(mask_load),
		.dok_(dok_),
		.lines(lines.intake)
	);

	// ------------------------------------------------------------------------
	// --- Channels -----------------------------------------------------------
	// ------------------------------------------------------------------------

	// One pending flip-flop per level
	for (genvar i = 0; i < IRQ_LEVELS; i++) begin : g_chan
		irq_channel chan (
			.__clk(__clk),
			.rst_n(rst_n),
			.set_req(lines.set_req[i]),
			.mask(lines.mask[i]),
			.clr_all(lines.clr_all[i]),
			.ack_clr(lines.ack_clr[i]),
			.ready(lines.ready[i])
		);
	end

	// ------------------------------------------------------------------------
	// --- Priority -----------------------------------------------------------
	// ------------------------------------------------------------------------

	irq_priority prio (
		.__clk(__clk),
		.rst_n(rst_n),
		.inta(inta),
		.irq(irq),
		.irq_level(irq_level),
		.lines(lines.encoder)
	);

endmodule

//--- dv/irq_board_properties.sv
`timescale 1ns/1ps

module irq_board_properties (
	input logic              __clk,
	input logic              rst_n,
	input logic              clm_,
	input logic              dok_,
	input logic              irq,
	input irq_pkg::level_t   irq_level,
	input irq_pkg::irq_vec_t ack_clr
);

	int fail_count = 0;

	// Bus answer is a single low cycle
	dok_single: assert property (@(posedge __clk) disable iff (!rst_n)
		!dok_ |=> dok_)
	else begin
		fail_count++;
		$error("dok_ low for two consecutive cycles");
	end

	// Acknowledge clear needs a shown interrupt and removes its level
	ack_needs_irq: assert property (@(posedge __clk) disable iff (!rst_n)
		(ack_clr != '0) |-> irq ##1 (!irq || irq_level != $past(irq_level)))
	else begin
		fail_count++;
		$error("ack_clr set while irq is low or acknowledged level still shown");
	end

	// Pending bits drop one edge after clm_ is seen and irq one edge later
	clear_drops_irq: assert property (@(posedge __clk) disable iff (!rst_n)
		!clm_ |-> ##3 !irq)
	else begin
		fail_count++;
		$error("irq still high two cycles after master clear");
	end

endmodule

bind irq_board irq_board_properties props (
	.__clk(__clk),
	.rst_n(rst_n),
	.clm_(clm_),
	.dok_(dok_),
	.irq(irq),
	.irq_level(irq_level),
	.ack_clr(lines.ack_clr)
);

//--- dv/irq_board_tb.sv
`timescale 1ns/1ps

module irq_board_tb;
	import irq_pkg::*;

	localparam int MAX_CYCLES = 2000;

	logic __clk;
	logic rst_n;
	logic clm_;
	logic pout_;
	logic zegar_;
	logic oprq_;
	logic rin_;
	word_t rdt_;
	word_t w;
	logic sint;
	logic mask_load;
	logic inta;
	logic dok_;
	logic irq;
	level_t irq_level;

	// Expected state of the board
	irq_vec_t exp_pend;
	irq_vec_t exp_mask;
	logic [31:0] rng_state = 32'd18337;
	int cycles = 0;

	irq_board dut (.*);

	initial begin
		__clk = 1'b0;
		forever #5 __clk = ~__clk;
	end

	always @(posedge __clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("Simulation failed");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	function automatic logic [31:0] next_random();
		logic [31:0] s;
		s = rng_state;
		s ^= s << 13;
		s ^= s >> 17;
		s ^= s << 5;
		rng_state = s;
		return s;
	endfunction

	function automatic logic model_irq();
		return |(exp_pend & exp_mask);
	endfunction

	// Lowest pending and enabled level
	function automatic level_t model_level();
		irq_vec_t r;
		r = exp_pend & exp_mask;
		for (int i = 0; i < IRQ_LEVELS; i++) begin
			if (r[i])
				return level_t'(i);
		end
		return '0;
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_level(input string name, input level_t exp, input level_t act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, exp, act);
			$display("Simulation failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic check_state();
		check_bit("irq", model_irq(), irq);
		if (model_irq())
			check_level("irq_level", model_level(), irq_level);
	endtask

	// ---------------------------------------------------------------------------
	// Stimulus
	// ---------------------------------------------------------------------------

	task automatic soft_request(input int lvl);
		@(posedge __clk);
		sint <= 1'b1;
		w <= word_t'(lvl);
		@(posedge __clk);
		sint <= 1'b0;
		exp_pend[lvl] = 1'b1;
		repeat (2) @(posedge __clk);
		@(negedge __clk);
		check_state();
	endtask

	task automatic load_mask(input irq_vec_t m);
		@(posedge __clk);
		mask_load <= 1'b1;
		w <= m;
		@(posedge __clk);
		mask_load <= 1'b0;
		exp_mask = m;
		exp_mask[0] = 1'b1;
		@(posedge __clk);
		@(negedge __clk);
		check_state();
	endtask

	task automatic acknowledge();
		level_t lvl;
		lvl = model_level();
		check_bit("irq before inta", 1'b1, irq);
		@(posedge __clk);
		inta <= 1'b1;
		@(posedge __clk);
		inta <= 1'b0;
		exp_pend[lvl] = 1'b0;
		@(negedge __clk);
		check_state();
	endtask

	task automatic drain();
		int prev;
		prev = -1;
		while (model_irq()) begin
			check_bit("irq_level ascending", 1'b1, int'(irq_level) > prev);
			prev = irq_level;
			acknowledge();
		end
	endtask

	task automatic drive_source(input int src, input logic v);
		case (src)
			0: pout_ <= v;
			1: zegar_ <= v;
			default: oprq_ <= v;
		endcase
	endtask

	// Expects nothing pending on entry
	task automatic fixed_source(input int src, input level_t lvl);
		@(posedge __clk);
		drive_source(src, 1'b0);
		@(posedge __clk);
		exp_pend[lvl] = 1'b1;
		@(posedge __clk);
		@(negedge __clk);
		check_bit("irq at E+1", 1'b0, irq);
		@(posedge __clk);
		@(negedge __clk);
		check_state();
		acknowledge();
		repeat (4) @(posedge __clk);
		@(negedge __clk);
		check_bit("irq with source held low", 1'b0, irq);
		@(posedge __clk);
		drive_source(src, 1'b1);
	endtask

	task automatic bus_request(input word_t r);
		level_t lvl;
		lvl = level_t'(15 - r[13:15]);
		@(posedge __clk);
		rin_ <= 1'b0;
		rdt_ <= r;
		@(posedge __clk);
		exp_pend[lvl] = 1'b1;
		@(negedge __clk);
		check_bit("dok_ after E", 1'b0, dok_);
		@(posedge __clk);
		rin_ <= 1'b1;
		@(negedge __clk);
		check_bit("dok_ after E+1", 1'b1, dok_);
		@(posedge __clk);
		@(negedge __clk);
		check_state();
	endtask

	task automatic master_clear();
		@(posedge __clk);
		clm_ <= 1'b0;
		@(posedge __clk);
		clm_ <= 1'b1;
		exp_pend = '0;
		repeat (2) @(posedge __clk);
		@(negedge __clk);
		check_bit("irq at C+2", 1'b0, irq);
	endtask

	// ---------------------------------------------------------------------------
	// Tests
	// ---------------------------------------------------------------------------

	task automatic test_reset_state();
		check_bit("irq", 1'b0, irq);
		check_bit("dok_", 1'b1, dok_);
		for (int i = 0; i < IRQ_LEVELS; i++) begin
			soft_request(i);
			acknowledge();
		end
	endtask

	task automatic test_fixed_sources();
		fixed_source(0, LVL_POWER);
		fixed_source(1, LVL_CLOCK);
		fixed_source(2, LVL_OPRQ);
	endtask

	task automatic test_priority();
		repeat (5)
			soft_request(int'(next_random() & 32'hf));
		drain();
	endtask

	task automatic test_masking();
		irq_vec_t m;
		m = irq_vec_t'(next_random());
		m[9] = 1'b0;
		load_mask(m);
		soft_request(9);
		repeat (3)
			soft_request(int'(next_random() & 32'hf));
		// Hidden levels come back
		load_mask('1);
		drain();
		load_mask('0);
		soft_request(0);
		acknowledge();
		load_mask('1);
	endtask

	task automatic test_bus();
		bus_request(16'hfff8);
		acknowledge();
		repeat (3) begin
			bus_request(word_t'(next_random()));
			acknowledge();
		end
	endtask

	task automatic test_master_clear();
		irq_vec_t m;
		m = '1;
		m[3] = 1'b0;
		load_mask(m);
		soft_request(2);
		soft_request(6);
		soft_request(11);
		master_clear();
		// Level 3 must still be masked
		soft_request(3);
		soft_request(4);
		load_mask('1);
		drain();
	endtask

	initial begin
		rst_n = 1'b0;
		clm_ = 1'b1;
		pout_ = 1'b1;
		zegar_ = 1'b1;
		oprq_ = 1'b1;
		rin_ = 1'b1;
		rdt_ = '1;
		w = '0;
		sint = 1'b0;
		mask_load = 1'b0;
		inta = 1'b0;
		exp_pend = '0;
		exp_mask = MASK_RESET;
		repeat (4) @(posedge __clk);
		rst_n <= 1'b1;
		@(negedge __clk);
		test_reset_state();
		test_fixed_sources();
		test_priority();
		test_masking();
		test_bus();
		test_master_clear();
		repeat (4) @(posedge __clk);
		if (dut.props.fail_count != 0) begin
			$display("%0d assertion failures on the bus and clear rules", dut.props.fail_count);
			$display("Simulation failed");
			$fatal(1, "assertion failures");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

//--- flist.f
design/irq_pkg.sv
design/irq_lines_if.sv
design/irq_intake.sv
design/irq_channel.sv
design/irq_priority.sv
design/irq_board.sv
dv/irq_board_properties.sv
dv/irq_board_tb.sv

//--- Bender.yml
package:
  name: irq_board

sources:
  - design/irq_pkg.sv
  - design/irq_lines_if.sv
  - design/irq_intake.sv
  - design/irq_channel.sv
  - design/irq_priority.sv
  - design/irq_board.sv
  - target: test
    files:
      - dv/irq_board_properties.sv
      - dv/irq_board_tb.sv
